// ==== rtl/ahb_bridge_pkg.sv ====
// AHB slave bridge shared definitions.
// Transfer, burst and size encodings, bridge FSM states and burst helpers.

package ahb_bridge_pkg;

    typedef enum logic [1:0] {
        TRANS_IDLE   = 2'd0,
        TRANS_BUSY   = 2'd1,
        TRANS_NONSEQ = 2'd2,
        TRANS_SEQ    = 2'd3
    } trans_t;

    typedef enum logic [2:0] {
        BURST_SINGLE = 3'd0,
        BURST_INCR   = 3'd1,
        BURST_WRAP4  = 3'd2,
        BURST_INCR4  = 3'd3,
        BURST_WRAP8  = 3'd4,
        BURST_INCR8  = 3'd5,
        BURST_WRAP16 = 3'd6,
        BURST_INCR16 = 3'd7
    } burst_t;

    typedef logic [2:0] size_t;  // Log2 of bytes per beat.

    typedef enum logic [1:0] {
        ST_IDLE       = 2'd0,
        ST_ACTIVE     = 2'd1,
        ST_ERR_FIRST  = 2'd2,
        ST_ERR_SECOND = 2'd3
    } bridge_state_t;

    localparam int BOUNDARY_BITS = 10;  // 1 KB burst boundary.
    localparam int BEAT_CNT_BITS = 4;

    // Beats after the first one; zero for SINGLE and INCR.
    function automatic logic [BEAT_CNT_BITS-1:0] burst_len(burst_t burst);
        case (burst)
            BURST_WRAP4, BURST_INCR4:   burst_len = 4'd3;
            BURST_WRAP8, BURST_INCR8:   burst_len = 4'd7;
            BURST_WRAP16, BURST_INCR16: burst_len = 4'd15;
            default:                    burst_len = '0;
        endcase
    endfunction

endpackage

// ==== rtl/ahb_req_if.sv ====
`timescale 1ns/10ps
// AHB address-phase request bundle.
// Carries the live transfer attributes from the AHB ports to the FSM
// and the command register.

interface ahb_req_if #(
    parameter int ADDR_WIDTH = 32
);

    logic [ADDR_WIDTH-1:0]  addr;
    ahb_bridge_pkg::burst_t burst;
    ahb_bridge_pkg::size_t  size;
    ahb_bridge_pkg::trans_t trans;
    logic                   write;
    logic                   sel;

    // Checks and sequencing.
    modport fsm_mp (
        input addr, burst, size, trans, write, sel
    );

    // Command capture.
    modport cmd_mp (
        input addr, burst, size, write
    );

endinterface

// ==== rtl/ahb_slave_fsm.sv ====
`timescale 1ns/10ps
// AHB slave bridge transfer FSM.
// Checks each NONSEQ request, steers command capture and burst steps,
// and runs the two-cycle AHB error response.

module ahb_slave_fsm #(
    parameter int DATA_WIDTH = 32
) (
    input  logic      ahb_clk_in,
    input  logic      ahb_rstn_in,
    ahb_req_if.fsm_mp req,
    input  logic      beats_left_zero,
    input  logic      cmd_active,
    input  logic      timeout,
    input  logic      other_ready_in,
    output logic      capture,
    output logic      step,
    output logic      clear,
    output logic      err_phase,
    output logic      other_error_out
);

    localparam int BB = ahb_bridge_pkg::BOUNDARY_BITS;

    ahb_bridge_pkg::bridge_state_t state;
    ahb_bridge_pkg::bridge_state_t next_state;

    logic [6:0]                               size_mask;
    logic [ahb_bridge_pkg::BEAT_CNT_BITS-1:0] span_beats;
    logic [BB+1:0]                            span_end;
    logic                                     size_ok;
    logic                                     addr_aligned;
    logic                                     bound_cross;
    logic                                     req_legal;
    logic                                     nonseq_req;
    logic                                     cont_req;
    logic                                     beat_done;
    logic                                     accept_slot;
    logic                                     bad_req;
    logic                                     stall_err;

    // ******************************************************************
    // Request checks
    // ******************************************************************
    always_comb begin
        size_mask  = 7'((8'd1 << req.size) - 8'd1);
        // Wrap bursts stay inside their own aligned window.
        if (req.burst inside {ahb_bridge_pkg::BURST_INCR4,
                              ahb_bridge_pkg::BURST_INCR8,
                              ahb_bridge_pkg::BURST_INCR16}) begin
            span_beats = ahb_bridge_pkg::burst_len(req.burst);
        end else begin
            span_beats = '0;
        end
        span_end     = (BB+2)'(req.addr[BB-1:0]) + ((BB+2)'(span_beats) << req.size);
        size_ok      = (8 << req.size) <= DATA_WIDTH;   // Beat fits the bus.
        addr_aligned = (req.addr[6:0] & size_mask) == 7'd0;
        bound_cross  = |span_end[BB+1:BB];              // Last beat past 1 KB.
        req_legal    = size_ok && addr_aligned && !bound_cross;
    end

    // ******************************************************************
    // Strobes
    // ******************************************************************
    always_comb begin
        nonseq_req  = req.sel && (req.trans == ahb_bridge_pkg::TRANS_NONSEQ);
        cont_req    = req.sel && (req.trans == ahb_bridge_pkg::TRANS_SEQ ||
                                  req.trans == ahb_bridge_pkg::TRANS_BUSY);
        beat_done   = (state == ahb_bridge_pkg::ST_ACTIVE) && other_ready_in;
        accept_slot = (state == ahb_bridge_pkg::ST_IDLE) || beat_done;
        capture     = accept_slot && nonseq_req && req_legal;
        bad_req     = accept_slot && nonseq_req && !req_legal;
        stall_err   = (state == ahb_bridge_pkg::ST_ACTIVE) && cmd_active &&
                      timeout && !other_ready_in;
        step        = beat_done && cont_req && !beats_left_zero;
        // Drop the command when its last beat ends or the error sequence closes.
        clear       = (beat_done && !step && !capture) ||
                      (state == ahb_bridge_pkg::ST_ERR_SECOND);
    end

    always_comb begin
        next_state = state;
        case (state)
            ahb_bridge_pkg::ST_IDLE: begin
                if (bad_req) begin
                    next_state = ahb_bridge_pkg::ST_ERR_FIRST;
                end else if (capture) begin
                    next_state = ahb_bridge_pkg::ST_ACTIVE;
                end
            end
            ahb_bridge_pkg::ST_ACTIVE: begin
                if (bad_req || stall_err) begin
                    next_state = ahb_bridge_pkg::ST_ERR_FIRST;
                end else if (!capture && (clear || !cmd_active)) begin
                    next_state = ahb_bridge_pkg::ST_IDLE;
                end
            end
            ahb_bridge_pkg::ST_ERR_FIRST:  next_state = ahb_bridge_pkg::ST_ERR_SECOND;
            ahb_bridge_pkg::ST_ERR_SECOND: next_state = ahb_bridge_pkg::ST_IDLE;
            default:                       next_state = ahb_bridge_pkg::ST_IDLE;
        endcase
    end

    always_ff @(posedge ahb_clk_in or negedge ahb_rstn_in) begin
        if (!ahb_rstn_in) begin
            state <= ahb_bridge_pkg::ST_IDLE;
        end else begin
            state <= next_state;
        end
    end

    assign err_phase       = (state == ahb_bridge_pkg::ST_ERR_FIRST) ||
                             (state == ahb_bridge_pkg::ST_ERR_SECOND);
    assign other_error_out = err_phase;  // Target sees the error window.

    // Both error cycles run before the target command drops.
    assert property (@(posedge ahb_clk_in) disable iff (!ahb_rstn_in)
        state == ahb_bridge_pkg::ST_ERR_FIRST |=>
            state == ahb_bridge_pkg::ST_ERR_SECOND ##1 !cmd_active);

endmodule

// ==== rtl/ahb_wait_timer.sv ====
`timescale 1ns/10ps
// Target stall timer.
// Counts consecutive cycles of ready low on an active command.

module ahb_wait_timer #(
    parameter int WAIT_TIMEOUT = 6
) (
    input  logic ahb_clk_in,
    input  logic ahb_rstn_in,
    input  logic cmd_active,
    input  logic other_ready_in,
    output logic timeout
);

    localparam int CNT_W = $clog2(WAIT_TIMEOUT + 1);

    logic [CNT_W-1:0] stall_cnt;

    always_ff @(posedge ahb_clk_in or negedge ahb_rstn_in) begin
        if (!ahb_rstn_in) begin
            stall_cnt <= '0;
        end else if (!cmd_active || other_ready_in) begin
            stall_cnt <= '0;                  // Stall run broken.
        end else if (!timeout) begin
            stall_cnt <= stall_cnt + 1'b1;
        end
    end

    // Saturates, so timeout holds until the command ends.
    assign timeout = (stall_cnt == CNT_W'(WAIT_TIMEOUT));

    // No target stall can outlast the limit with the command still running.
    assert property (@(posedge ahb_clk_in) disable iff (!ahb_rstn_in)
        (timeout && !other_ready_in) |-> ##3 !cmd_active);

endmodule

// ==== rtl/ahb_burst_addr_gen.sv ====
`timescale 1ns/10ps
// Target command register and burst address generator.
// Holds the captured command, counts remaining beats and steps the
// address for incrementing and wrapping bursts.

module ahb_burst_addr_gen #(
    parameter int ADDR_WIDTH = 32
) (
    input  logic                  ahb_clk_in,
    input  logic                  ahb_rstn_in,
    ahb_req_if.cmd_mp             cmd,
    input  logic                  capture,
    input  logic                  step,
    input  logic                  clear,
    output logic [ADDR_WIDTH-1:0] other_addr_out,
    output ahb_bridge_pkg::size_t other_size_out,
    output logic                  other_write_out,
    output logic                  other_sel_out,
    output logic                  cmd_active,
    output logic                  beats_left_zero
);

    ahb_bridge_pkg::burst_t                   burst_q;
    logic [ahb_bridge_pkg::BEAT_CNT_BITS-1:0] beat_cnt;
    logic [ADDR_WIDTH-1:0]                    incr_addr;
    logic [ADDR_WIDTH-1:0]                    wrap_mask;
    logic [ADDR_WIDTH-1:0]                    next_addr;
    logic                                     is_wrap;
    logic                                     is_incr;

    // ******************************************************************
    // Next beat address
    // ******************************************************************
    always_comb begin
        is_wrap   = burst_q inside {ahb_bridge_pkg::BURST_WRAP4,
                                    ahb_bridge_pkg::BURST_WRAP8,
                                    ahb_bridge_pkg::BURST_WRAP16};
        is_incr   = (burst_q == ahb_bridge_pkg::BURST_INCR);
        incr_addr = other_addr_out + (ADDR_WIDTH'(1) << other_size_out);
        // Window of beats times beat size.
        wrap_mask = ((ADDR_WIDTH'(ahb_bridge_pkg::burst_len(burst_q)) + ADDR_WIDTH'(1))
                     << other_size_out) - ADDR_WIDTH'(1);
        if (is_wrap) begin
            next_addr = (other_addr_out & ~wrap_mask) | (incr_addr & wrap_mask);
        end else begin
            next_addr = incr_addr;
        end
    end

    // ******************************************************************
    // Command register
    // ******************************************************************
    always_ff @(posedge ahb_clk_in or negedge ahb_rstn_in) begin
        if (!ahb_rstn_in) begin
            other_addr_out  <= '0;
            other_size_out  <= '0;
            other_write_out <= 1'b0;
            other_sel_out   <= 1'b0;
            burst_q         <= ahb_bridge_pkg::BURST_SINGLE;
            beat_cnt        <= '0;
        end else if (capture) begin
            other_addr_out  <= cmd.addr;
            other_size_out  <= cmd.size;
            other_write_out <= cmd.write;
            other_sel_out   <= 1'b1;
            burst_q         <= cmd.burst;
            beat_cnt        <= ahb_bridge_pkg::burst_len(cmd.burst);
        end else if (step) begin
            other_addr_out <= next_addr;
            if (!is_incr && beat_cnt != '0) begin
                beat_cnt <= beat_cnt - 1'b1;  // INCR runs until the master stops.
            end
        end else if (clear) begin
            other_sel_out <= 1'b0;
        end
    end

    assign cmd_active      = other_sel_out;
    assign beats_left_zero = (beat_cnt == '0) && !is_incr;

    // Only aligned requests pass the FSM checks, and stepping keeps them so.
    assert property (@(posedge ahb_clk_in) disable iff (!ahb_rstn_in)
        other_sel_out |->
            ((other_addr_out[6:0] & 7'((8'd1 << other_size_out) - 8'd1)) == 7'd0));

endmodule

// ==== rtl/ahb_data_path.sv ====
`timescale 1ns/10ps
// AHB slave bridge data path.
// Registers write and read data, forwards target ready and error,
// and forces the two-cycle AHB error response.

module ahb_data_path #(
    parameter int DATA_WIDTH = 32
) (
    input  logic                  ahb_clk_in,
    input  logic                  ahb_rstn_in,
    input  logic [DATA_WIDTH-1:0] ahb_wdata_in,
    input  logic [DATA_WIDTH-1:0] other_rdata_in,
    input  logic                  other_ready_in,
    input  logic                  other_error_in,
    input  logic                  other_write_out,
    input  logic                  cmd_active,
    input  logic                  err_phase,
    output logic [DATA_WIDTH-1:0] other_wdata_out,
    output logic [DATA_WIDTH-1:0] ahb_rdata_out,
    output logic                  ahb_ready_out,
    output logic                  ahb_resp_out
);

    logic err_seen;  // Previous cycle was already in error.

    always_ff @(posedge ahb_clk_in or negedge ahb_rstn_in) begin
        if (!ahb_rstn_in) begin
            err_seen        <= 1'b0;
            ahb_ready_out   <= 1'b0;
            ahb_resp_out    <= 1'b0;
            other_wdata_out <= '0;
            ahb_rdata_out   <= '0;
        end else begin
            err_seen <= err_phase;
            if (err_phase) begin
                ahb_ready_out   <= err_seen;       // 0 then 1.
                ahb_resp_out    <= 1'b1;
                other_wdata_out <= '0;
                ahb_rdata_out   <= '0;
            end else if (cmd_active) begin
                ahb_ready_out   <= other_ready_in;
                ahb_resp_out    <= other_error_in;
                other_wdata_out <= other_write_out ? ahb_wdata_in : '0;
                ahb_rdata_out   <= other_write_out ? '0 : other_rdata_in;
            end else begin
                ahb_ready_out   <= 1'b1;           // Idle slave is ready.
                ahb_resp_out    <= 1'b0;
                other_wdata_out <= '0;
                ahb_rdata_out   <= '0;
            end
        end
    end

endmodule

// ==== rtl/ahb_slave_bridge.sv ====
`timescale 1ns/10ps
// AHB slave bridge top level.
// Connects the AHB ports to the request bundle, the transfer FSM,
// stall timer, burst address generator and data path.

module ahb_slave_bridge #(
    parameter int ADDR_WIDTH   = 32,
    parameter int DATA_WIDTH   = 32,
    parameter int WAIT_TIMEOUT = 6
) (
    input  logic                  ahb_clk_in,
    input  logic                  ahb_rstn_in,
    input  logic [ADDR_WIDTH-1:0] ahb_addr_in,
    input  logic [2:0]            ahb_burst_in,
    input  logic [2:0]            ahb_size_in,
    input  logic [1:0]            ahb_trans_in,
    input  logic                  ahb_write_in,
    input  logic                  ahb_sel_in,
    input  logic [DATA_WIDTH-1:0] ahb_wdata_in,
    input  logic [DATA_WIDTH-1:0] other_rdata_in,
    input  logic                  other_ready_in,
    input  logic                  other_error_in,
    output logic [DATA_WIDTH-1:0] ahb_rdata_out,
    output logic                  ahb_ready_out,
    output logic                  ahb_resp_out,
    output logic [ADDR_WIDTH-1:0] other_addr_out,
    output logic [2:0]            other_size_out,
    output logic                  other_write_out,
    output logic                  other_sel_out,
    output logic [DATA_WIDTH-1:0] other_wdata_out,
    output logic                  other_error_out
);

    logic capture;
    logic step;
    logic clear;
    logic err_phase;
    logic beats_left_zero;
    logic cmd_active;
    logic timeout;

    // ******************************************************************
    // Address-phase request
    // ******************************************************************
    ahb_req_if #(.ADDR_WIDTH(ADDR_WIDTH)) req_bus ();

    assign req_bus.addr  = ahb_addr_in;
    assign req_bus.burst = ahb_bridge_pkg::burst_t'(ahb_burst_in);
    assign req_bus.size  = ahb_size_in;
    assign req_bus.trans = ahb_bridge_pkg::trans_t'(ahb_trans_in);
    assign req_bus.write = ahb_write_in;
    assign req_bus.sel   = ahb_sel_in;

    ahb_slave_fsm #(.DATA_WIDTH(DATA_WIDTH)) i_fsm (
        .ahb_clk_in      (ahb_clk_in),
        .ahb_rstn_in     (ahb_rstn_in),
        .req             (req_bus.fsm_mp),
        .beats_left_zero (beats_left_zero),
        .cmd_active      (cmd_active),
        .timeout         (timeout),
        .other_ready_in  (other_ready_in),
        .capture         (capture),
        .step            (step),
        .clear           (clear),
        .err_phase       (err_phase),
        .other_error_out (other_error_out)
    );

    ahb_wait_timer #(.WAIT_TIMEOUT(WAIT_TIMEOUT)) i_wait_timer (
        .ahb_clk_in     (ahb_clk_in),
        .ahb_rstn_in    (ahb_rstn_in),
        .cmd_active     (cmd_active),
        .other_ready_in (other_ready_in),
        .timeout        (timeout)
    );

    ahb_burst_addr_gen #(.ADDR_WIDTH(ADDR_WIDTH)) i_burst_addr_gen (
        .ahb_clk_in      (ahb_clk_in),
        .ahb_rstn_in     (ahb_rstn_in),
        .cmd             (req_bus.cmd_mp),
        .capture         (capture),
        .step            (step),
        .clear           (clear),
        .other_addr_out  (other_addr_out),
        .other_size_out  (other_size_out),
        .other_write_out (other_write_out),
        .other_sel_out   (other_sel_out),
        .cmd_active      (cmd_active),
        .beats_left_zero (beats_left_zero)
    );

    ahb_data_path #(.DATA_WIDTH(DATA_WIDTH)) i_data_path (
        .ahb_clk_in      (ahb_clk_in),
        .ahb_rstn_in     (ahb_rstn_in),
        .ahb_wdata_in    (ahb_wdata_in),
        .other_rdata_in  (other_rdata_in),
        .other_ready_in  (other_ready_in),
        .other_error_in  (other_error_in),
        .other_write_out (other_write_out),
        .cmd_active      (cmd_active),
        .err_phase       (err_phase),
        .other_wdata_out (other_wdata_out),
        .ahb_rdata_out   (ahb_rdata_out),
        .ahb_ready_out   (ahb_ready_out),
        .ahb_resp_out    (ahb_resp_out)
    );

endmodule

// ==== verification/tb_ahb_slave_bridge.sv ====
`timescale 1ns/10ps
// Directed testbench for the AHB slave bridge.
// Drives AHB transfers and models a target that answers with address-based data.

module tb_ahb_slave_bridge;

    localparam int ADDR_WIDTH   = 32;
    localparam int DATA_WIDTH   = 32;
    localparam int WAIT_TIMEOUT = 6;
    localparam int WAIT_LIMIT   = 40;       // Cycles per wait loop.
    localparam logic [31:0] RAND_SEED = 32'h31a5;

    logic                  ahb_clk_in;
    logic                  ahb_rstn_in;
    logic [ADDR_WIDTH-1:0] ahb_addr_in;
    logic [2:0]            ahb_burst_in;
    logic [2:0]            ahb_size_in;
    logic [1:0]            ahb_trans_in;
    logic                  ahb_write_in;
    logic                  ahb_sel_in;
    logic [DATA_WIDTH-1:0] ahb_wdata_in;
    logic [DATA_WIDTH-1:0] other_rdata_in;
    logic                  other_ready_in;
    logic                  other_error_in;
    logic [DATA_WIDTH-1:0] ahb_rdata_out;
    logic                  ahb_ready_out;
    logic                  ahb_resp_out;
    logic [ADDR_WIDTH-1:0] other_addr_out;
    logic [2:0]            other_size_out;
    logic                  other_write_out;
    logic                  other_sel_out;
    logic [DATA_WIDTH-1:0] other_wdata_out;
    logic                  other_error_out;

    int          err_cnt;     // Errors in the running test.
    int          total_err;
    int          pass_cnt;
    int          fail_cnt;
    int          stall_mode;  // 0 ready, 1 random stalls, 2 never ready.
    int          stall_run;
    logic [31:0] first_rand;

    ahb_slave_bridge #(
        .ADDR_WIDTH   (ADDR_WIDTH),
        .DATA_WIDTH   (DATA_WIDTH),
        .WAIT_TIMEOUT (WAIT_TIMEOUT)
    ) i_ahb_slave_bridge (.*);

    always #10 ahb_clk_in = ~ahb_clk_in;

    function automatic logic [31:0] target_data(logic [31:0] addr);
        return {~addr[15:0], addr[15:0]} ^ 32'h5a3c_0000;
    endfunction

    // ******************************************************************
    // Target responder
    // ******************************************************************
    always begin
        @(posedge ahb_clk_in);
        #2;
        other_rdata_in = target_data(other_addr_out);
        other_error_in = 1'b0;
        if (other_sel_out && stall_mode == 0) begin
            other_ready_in = 1'b1;
        end else if (other_sel_out && stall_mode == 1) begin
            // At most two stalls in a row, well below the timeout.
            if (stall_run < 2 && ($urandom % 3) == 0) begin
                other_ready_in = 1'b0;
                stall_run++;
            end else begin
                other_ready_in = 1'b1;
                stall_run = 0;
            end
        end else begin
            other_ready_in = 1'b0;
        end
    end

    // ******************************************************************
    // Helpers
    // ******************************************************************
    task automatic drive_idle();
        ahb_sel_in   = 1'b0;
        ahb_trans_in = ahb_bridge_pkg::TRANS_IDLE;
        ahb_addr_in  = '0;
        ahb_burst_in = ahb_bridge_pkg::BURST_SINGLE;
        ahb_size_in  = 3'd0;
        ahb_write_in = 1'b0;
    endtask

    // Address phase, returns 2 ns after the edge that samples it.
    task automatic start_transfer(logic [31:0] addr, logic [2:0] size,
                                  logic [2:0] burst, logic write);
        @(posedge ahb_clk_in);
        #2;
        ahb_sel_in   = 1'b1;
        ahb_trans_in = ahb_bridge_pkg::TRANS_NONSEQ;
        ahb_addr_in  = addr;
        ahb_size_in  = size;
        ahb_burst_in = burst;
        ahb_write_in = write;
        @(posedge ahb_clk_in);
        #2;
    endtask

    task automatic check_value(string test, string what, logic [31:0] exp, logic [31:0] act);
        assert (act === exp) else begin
            $display("Mismatch in %s, %s: expected 0x%h, actual 0x%h", test, what, exp, act);
            err_cnt++;
        end
    endtask

    // Beat is seen mid-cycle and completes on the next rising edge.
    task automatic wait_beat(string test, output logic [31:0] beat_addr, output bit ok);
        int n;
        ok = 1'b0;
        beat_addr = '0;
        for (n = 0; n < WAIT_LIMIT && !ok; n++) begin
            @(negedge ahb_clk_in);
            if (other_sel_out && other_ready_in) begin
                beat_addr = other_addr_out;
                ok = 1'b1;
            end
        end
        assert (ok) else begin
            $display("%s: no target beat completed within %0d cycles", test, WAIT_LIMIT);
            err_cnt++;
        end
        if (ok) begin
            @(posedge ahb_clk_in);
            #2;
        end
    endtask

    task automatic wait_idle(string test);
        int n;
        for (n = 0; n < WAIT_LIMIT && other_sel_out; n++) begin
            @(posedge ahb_clk_in);
            #2;
        end
        assert (!other_sel_out) else begin
            $display("%s: other_sel_out still high after %0d cycles", test, WAIT_LIMIT);
            err_cnt++;
        end
    endtask

    task automatic close_test(string test);
        wait_idle(test);
        repeat (4) @(posedge ahb_clk_in);
        if (err_cnt == 0) begin
            $display("%s: passed", test);
            pass_cnt++;
        end else begin
            $display("%s: failed with %0d errors", test, err_cnt);
            fail_cnt++;
        end
        total_err += err_cnt;
        err_cnt = 0;
    endtask

    // ******************************************************************
    // Tests
    // ******************************************************************
    task automatic single_write();
        logic [31:0] data;
        logic [31:0] baddr;
        bit          ok;
        data = $urandom;
        start_transfer(32'h0000_1204, 3'd2, ahb_bridge_pkg::BURST_SINGLE, 1'b1);
        drive_idle();
        ahb_wdata_in = data;  // Data phase.
        check_value("single_write", "other_sel_out", 32'd1, other_sel_out);
        check_value("single_write", "other_addr_out", 32'h0000_1204, other_addr_out);
        check_value("single_write", "other_write_out", 32'd1, other_write_out);
        check_value("single_write", "other_size_out", 32'd2, other_size_out);
        wait_beat("single_write", baddr, ok);
        if (ok) begin
            check_value("single_write", "other_wdata_out", data, other_wdata_out);
            check_value("single_write", "ahb_ready_out", 32'd1, ahb_ready_out);
            check_value("single_write", "ahb_resp_out", 32'd0, ahb_resp_out);
        end
        ahb_wdata_in = '0;
        close_test("single_write");
    endtask

    task automatic single_read();
        logic [31:0] baddr;
        bit          ok;
        start_transfer(32'h0000_2a10, 3'd2, ahb_bridge_pkg::BURST_SINGLE, 1'b0);
        drive_idle();
        check_value("single_read", "other_write_out", 32'd0, other_write_out);
        wait_beat("single_read", baddr, ok);
        if (ok) begin
            check_value("single_read", "beat address", 32'h0000_2a10, baddr);
            check_value("single_read", "ahb_rdata_out", target_data(32'h0000_2a10),
                        ahb_rdata_out);
        end
        close_test("single_read");
    endtask

    // Four-beat read; wrap bursts fold inside a 16-byte window.
    task automatic burst_read(string test, logic [31:0] start, logic [2:0] burst,
                              bit wrap);
        logic [31:0] baddr;
        logic [31:0] exp_addr;
        bit          ok;
        int          i;
        start_transfer(start, 3'd2, burst, 1'b0);
        ahb_trans_in = ahb_bridge_pkg::TRANS_SEQ;
        ok = 1'b1;
        for (i = 0; i < 4 && ok; i++) begin
            exp_addr = start + 32'(4 * i);
            if (wrap) begin
                exp_addr = (start & ~32'hF) | (exp_addr & 32'hF);
            end
            wait_beat(test, baddr, ok);
            if (ok) begin
                check_value(test, "other_addr_out", exp_addr, baddr);
                check_value(test, "ahb_rdata_out", target_data(exp_addr), ahb_rdata_out);
            end
        end
        drive_idle();
        stall_mode = 0;
        close_test(test);
    endtask

    task automatic misaligned_error();
        int n;
        start_transfer(32'h0000_0002, 3'd2, ahb_bridge_pkg::BURST_SINGLE, 1'b0);
        drive_idle();
        for (n = 0; n < WAIT_LIMIT && !ahb_resp_out; n++) begin
            check_value("misaligned_error", "other_sel_out", 32'd0, other_sel_out);
            @(posedge ahb_clk_in);
            #2;
        end
        assert (ahb_resp_out) else begin
            $display("misaligned_error: no error response within %0d cycles", WAIT_LIMIT);
            err_cnt++;
        end
        if (ahb_resp_out) begin
            check_value("misaligned_error", "first ahb_ready_out", 32'd0, ahb_ready_out);
            check_value("misaligned_error", "other_error_out", 32'd1, other_error_out);
            @(posedge ahb_clk_in);
            #2;
            check_value("misaligned_error", "second ahb_ready_out", 32'd1, ahb_ready_out);
            check_value("misaligned_error", "second ahb_resp_out", 32'd1, ahb_resp_out);
            check_value("misaligned_error", "other_sel_out", 32'd0, other_sel_out);
        end
        close_test("misaligned_error");
    endtask

    task automatic stall_timeout();
        int n;
        int stalled;
        stall_mode = 2;
        stalled = 0;
        start_transfer(32'h0000_4400, 3'd2, ahb_bridge_pkg::BURST_SINGLE, 1'b0);
        drive_idle();
        for (n = 0; n < WAIT_LIMIT && !ahb_resp_out; n++) begin
            if (other_sel_out) begin
                stalled++;
            end
            @(posedge ahb_clk_in);
            #2;
        end
        assert (ahb_resp_out) else begin
            $display("stall_timeout: no error response within %0d cycles", WAIT_LIMIT);
            err_cnt++;
        end
        if (ahb_resp_out) begin
            // Timer limit, then one cycle each for the FSM and the data path.
            check_value("stall_timeout", "stalled cycles", WAIT_TIMEOUT + 2, stalled);
            check_value("stall_timeout", "first ahb_ready_out", 32'd0, ahb_ready_out);
            check_value("stall_timeout", "other_error_out", 32'd1, other_error_out);
            @(posedge ahb_clk_in);
            #2;
            check_value("stall_timeout", "second ahb_ready_out", 32'd1, ahb_ready_out);
            check_value("stall_timeout", "second ahb_resp_out", 32'd1, ahb_resp_out);
        end
        wait_idle("stall_timeout");
        stall_mode = 0;
        close_test("stall_timeout");
    endtask

    initial begin
        ahb_clk_in     = 1'b0;
        ahb_rstn_in    = 1'b0;
        drive_idle();
        ahb_wdata_in   = '0;
        other_rdata_in = '0;
        other_ready_in = 1'b0;
        other_error_in = 1'b0;
        err_cnt        = 0;
        total_err      = 0;
        pass_cnt       = 0;
        fail_cnt       = 0;
        stall_mode     = 0;
        stall_run      = 0;
        first_rand     = $urandom(RAND_SEED);
        repeat (10) @(posedge ahb_clk_in);
        #2;
        ahb_rstn_in = 1'b1;

        single_write();
        single_read();
        stall_mode = 1;
        burst_read("incr4_burst", $urandom & 32'h000f_fff0, ahb_bridge_pkg::BURST_INCR4, 0);
        burst_read("wrap4_burst", 32'h0000_0038, ahb_bridge_pkg::BURST_WRAP4, 1);
        misaligned_error();
        stall_timeout();

        $display("Tests passed %0d, failed %0d, errors %0d", pass_cnt, fail_cnt, total_err);
        if (fail_cnt == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

// ==== ahb_slave_bridge.f ====
rtl/ahb_bridge_pkg.sv
rtl/ahb_req_if.sv
rtl/ahb_slave_fsm.sv
rtl/ahb_wait_timer.sv
rtl/ahb_burst_addr_gen.sv
rtl/ahb_data_path.sv
rtl/ahb_slave_bridge.sv
verification/tb_ahb_slave_bridge.sv
